// File: flist.f
logic/wb_pkg.sv
logic/regfile.sv
logic/excp_encoder.sv
logic/csr_commit.sv
logic/perf_counter.sv
logic/wb_stage.sv
logic/wb_top.sv
bench/wb_tb.sv

// File: Bender.yml
package:
  name: wb_commit

sources:
  - logic/wb_pkg.sv
  - logic/regfile.sv
  - logic/excp_encoder.sv
  - logic/csr_commit.sv
  - logic/perf_counter.sv
  - logic/wb_stage.sv
  - logic/wb_top.sv
  - target: simulation
    files:
      - bench/wb_tb.sv

// File: bench/wb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wb_tb;
    import wb_pkg::*;

    localparam int clk_period    = 8;
    localparam int allowin_limit = 50; // cycles

    logic                  clk;
    logic                  arst_n;
    logic                  ms_valid;
    logic [xlen-1:0]       ms_pc;
    logic [xlen-1:0]       ms_result;
    logic [reg_addr_w-1:0] ms_dest;
    logic                  ms_gr_we;
    logic                  ms_excp;
    logic [excp_num_w-1:0] ms_excp_num;
    logic                  ms_ertn;
    logic                  ms_csr_we;
    logic [csr_addr_w-1:0] ms_csr_idx;
    logic [xlen-1:0]       ms_csr_wdata;
    logic                  ms_ll;
    logic                  ms_sc;
    logic [xlen-1:0]       ms_error_va;
    logic                  ms_br_inst;
    logic                  ms_br_pre_error;
    logic                  ms_mem_inst;
    logic                  break_point;
    logic [reg_addr_w-1:0] rf_raddr;
    logic [csr_addr_w-1:0] csr_raddr;
    logic                  allowin;
    logic                  excp_flush;
    logic                  ertn_flush;
    logic                  refetch_flush;
    logic [xlen-1:0]       rf_rdata;
    logic [xlen-1:0]       csr_rdata;
    logic [xlen-1:0]       cnt_retired;
    logic [xlen-1:0]       cnt_branch;
    logic [xlen-1:0]       cnt_mispredict;
    logic [xlen-1:0]       cnt_mem;

    // instruction being prepared for the next send
    logic [xlen-1:0]       i_pc;
    logic [xlen-1:0]       i_result;
    logic [reg_addr_w-1:0] i_dest;
    logic                  i_gr_we;
    logic [excp_num_w-1:0] i_excp_num;
    logic                  i_csr_we;
    logic [csr_addr_w-1:0] i_csr_idx;
    logic [xlen-1:0]       i_csr_wdata;
    logic                  i_ll;
    logic                  i_sc;
    logic [xlen-1:0]       i_error_va;
    logic                  i_br;
    logic                  i_mis;
    logic                  i_mem;
    logic                  i_ertn;

    // reference model
    logic [xlen-1:0] model_rf  [32];
    logic [xlen-1:0] model_csr [128];
    logic [xlen-1:0] model_cnt [4];

    int n_checks;
    int n_errors;
    int n_timeouts;

    wb_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic int lowest_bit(input logic [excp_num_w-1:0] v);
        int b;
        b = -1;
        for (int i = 0; i < excp_num_w; i++) begin
            if (v[i] && b < 0) b = i;
        end
        return b;
    endfunction

    function automatic logic [ecode_w-1:0] code_for_bit(input int b);
        case (b)
            1:       return ecode_adef;
            2, 11:   return ecode_tlbr; // fetch and data side refill
            3:       return ecode_pif;
            4, 13:   return ecode_ppi;
            5:       return ecode_sys;
            6:       return ecode_brk;
            7:       return ecode_ine;
            8:       return ecode_ipe;
            9:       return ecode_ale;
            12:      return ecode_pme;
            14:      return ecode_pis;
            15:      return ecode_pil;
            default: return ecode_int;
        endcase
    endfunction

    function automatic logic [excp_num_w-1:0] random_causes();
        logic [excp_num_w-1:0] v;
        v = excp_num_w'($urandom) & 16'hfbff; // bit 10 is unused
        if (v == '0) v = 16'h0200;
        return v;
    endfunction

    task automatic check_reg(input logic [reg_addr_w-1:0] addr, input logic [xlen-1:0] exp);
        @(posedge clk);
        rf_raddr <= addr;
        @(negedge clk);
        n_checks++;
        if (rf_rdata !== exp) begin
            n_errors++;
            $display("CHECK FAILED @ %0t: r%0d got %h expected %h", $time, addr, rf_rdata, exp);
        end
    endtask

    task automatic check_csr(input logic [csr_addr_w-1:0] idx, input logic [xlen-1:0] exp);
        @(posedge clk);
        csr_raddr <= idx;
        @(negedge clk);
        n_checks++;
        if (csr_rdata !== exp) begin
            n_errors++;
            $display("CHECK FAILED @ %0t: csr %0d got %h expected %h",
                     $time, idx, csr_rdata, exp);
        end
    endtask

    task automatic check_count(input string what, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED @ %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED @ %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic clear_inst(input int k);
        i_pc        = 32'h1c00_0000 + 32'(k) * 4;
        i_result    = $urandom;
        i_dest      = reg_addr_w'($urandom);
        i_gr_we     = 1'b0;
        i_excp_num  = '0;
        i_csr_we    = 1'b0;
        i_csr_idx   = '0;
        i_csr_wdata = $urandom;
        i_ll        = 1'b0;
        i_sc        = 1'b0;
        i_error_va  = $urandom;
        i_br        = 1'b0;
        i_mis       = 1'b0;
        i_mem       = 1'b0;
        i_ertn      = 1'b0;
    endtask

    // offer the instruction and hold it until the stage takes it
    task automatic send_inst(output bit sent);
        int waited;
        @(posedge clk);
        ms_pc           <= i_pc;
        ms_result       <= i_result;
        ms_dest         <= i_dest;
        ms_gr_we        <= i_gr_we;
        ms_excp         <= |i_excp_num;
        ms_excp_num     <= i_excp_num;
        ms_ertn         <= i_ertn;
        ms_csr_we       <= i_csr_we;
        ms_csr_idx      <= i_csr_idx;
        ms_csr_wdata    <= i_csr_wdata;
        ms_ll           <= i_ll;
        ms_sc           <= i_sc;
        ms_error_va     <= i_error_va;
        ms_br_inst      <= i_br;
        ms_br_pre_error <= i_mis;
        ms_mem_inst     <= i_mem;
        ms_valid        <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!allowin && waited < allowin_limit) begin
            @(negedge clk);
            waited++;
        end
        sent = allowin;
        if (!sent) begin
            n_timeouts++;
            $display("timeout: allowin stayed low for %0d cycles at %0t", waited, $time);
        end
        @(posedge clk); // transfer edge when allowin was high
        ms_valid <= 1'b0;
    endtask

    task automatic model_commit();
        int b;
        b = lowest_bit(i_excp_num);
        if (b >= 0) begin
            model_csr[csr_era] = i_pc;
            model_csr[csr_estat][21:16] = code_for_bit(b);
            model_csr[csr_estat][30:22] = 9'd0; // all modelled causes carry subcode 0
            if (b >= 1 && b <= 4) model_csr[csr_badv] = i_pc;
            else if (b == 9 || b >= 11) model_csr[csr_badv] = i_error_va;
        end else begin
            if (i_gr_we && i_dest != '0) model_rf[i_dest] = i_result;
            if (i_csr_we) begin
                if (i_csr_idx == csr_llbctl) begin
                    model_csr[csr_llbctl][31:1] = i_csr_wdata[31:1]; // bit 0 is the ll bit
                end else if (i_csr_idx == csr_era || i_csr_idx == csr_estat ||
                             i_csr_idx == csr_badv || i_csr_idx == csr_save0) begin
                    model_csr[i_csr_idx] = i_csr_wdata;
                end
            end
            if (i_ll) model_csr[csr_llbctl][0] = 1'b1;
            if (i_sc) model_csr[csr_llbctl][0] = 1'b0;
            model_cnt[0]++;
            if (i_br) model_cnt[1]++;
            if (i_mis) model_cnt[2]++;
            if (i_mem) model_cnt[3]++;
        end
    endtask

    // send, check the flushes while held, let it commit
    task automatic run_inst();
        bit   sent;
        logic exp_excp;
        logic exp_refetch;
        exp_excp    = (i_excp_num != '0);
        exp_refetch = i_csr_we || ((i_ll || i_sc) && !exp_excp);
        send_inst(sent);
        if (sent) begin
            @(negedge clk);
            check_flag("excp_flush", excp_flush, exp_excp);
            check_flag("refetch_flush", refetch_flush, exp_refetch);
            check_flag("ertn_flush", ertn_flush, i_ertn);
            @(posedge clk);
            model_commit();
        end
    endtask

    task automatic check_counters();
        @(negedge clk);
        check_count("cnt_retired", cnt_retired, model_cnt[0]);
        check_count("cnt_branch", cnt_branch, model_cnt[1]);
        check_count("cnt_mispredict", cnt_mispredict, model_cnt[2]);
        check_count("cnt_mem", cnt_mem, model_cnt[3]);
    endtask

    task automatic test_reg_writes();
        for (int k = 0; k < 12; k++) begin
            clear_inst(k);
            i_gr_we = 1'b1;
            if (k == 3 || k == 8) i_dest = '0;
            run_inst();
            check_reg(i_dest, model_rf[i_dest]);
        end
        check_reg('0, '0);
        for (int r = 0; r < 32; r++) check_reg(reg_addr_w'(r), model_rf[r]);
    endtask

    task automatic test_exceptions();
        logic [excp_num_w-1:0] fixed_causes [3];
        fixed_causes[0] = 16'h1200; // ale with pme behind it
        fixed_causes[1] = 16'h0221; // int first, badv untouched
        fixed_causes[2] = 16'h0208; // pif reports the pc
        for (int k = 0; k < 9; k++) begin
            clear_inst(100 + k);
            i_gr_we    = 1'b1;
            i_dest     = 5'd9;
            i_excp_num = (k < 3) ? fixed_causes[k] : random_causes();
            run_inst();
            check_reg(5'd9, model_rf[9]);
            check_csr(csr_era, model_csr[csr_era]);
            check_csr(csr_estat, model_csr[csr_estat]);
            check_csr(csr_badv, model_csr[csr_badv]);
        end
    endtask

    task automatic test_csr_write();
        clear_inst(200);
        i_csr_we  = 1'b1;
        i_csr_idx = csr_save0;
        run_inst();
        check_csr(csr_save0, model_csr[csr_save0]);
        clear_inst(201);
        i_csr_we   = 1'b1;
        i_csr_idx  = csr_save0;
        i_excp_num = 16'h0020; // syscall beats the write
        run_inst();
        check_csr(csr_save0, model_csr[csr_save0]);
        check_csr(csr_estat, model_csr[csr_estat]);
    endtask

    task automatic test_ll_sc();
        clear_inst(300);
        i_ll    = 1'b1;
        i_gr_we = 1'b1;
        i_mem   = 1'b1;
        run_inst();
        check_csr(csr_llbctl, model_csr[csr_llbctl]);
        clear_inst(301);
        i_sc    = 1'b1;
        i_gr_we = 1'b1;
        i_mem   = 1'b1;
        run_inst();
        check_csr(csr_llbctl, model_csr[csr_llbctl]);
    endtask

    task automatic test_back_pressure();
        bit sent;
        clear_inst(400);
        i_gr_we = 1'b1;
        i_dest  = 5'd7;
        @(posedge clk);
        break_point <= 1'b1;
        send_inst(sent);
        for (int k = 0; k < 6; k++) begin
            @(negedge clk);
            check_flag("allowin under break_point", allowin, 1'b0);
        end
        check_reg(5'd7, model_rf[7]); // still the old value
        check_count("cnt_retired held", cnt_retired, model_cnt[0]);
        @(posedge clk);
        break_point <= 1'b0;
        @(posedge clk); // commit edge
        if (sent) model_commit();
        repeat (3) @(posedge clk);
        check_reg(5'd7, model_rf[7]);
        check_counters();
    endtask

    task automatic test_counter_mix();
        for (int k = 0; k < 24; k++) begin
            clear_inst(500 + k);
            i_gr_we = 1'($urandom % 2);
            i_br    = 1'($urandom % 2);
            i_mis   = i_br && ($urandom % 3 == 0);
            i_mem   = !i_br && ($urandom % 2);
            i_ertn  = ($urandom % 6 == 0);
            if ($urandom % 4 == 0) i_excp_num = random_causes();
            run_inst();
        end
        check_counters();
    endtask

    initial begin
        void'($urandom(32'hf254_375d));
        arst_n          = 1'b0;
        ms_valid        = 1'b0;
        ms_pc           = '0;
        ms_result       = '0;
        ms_dest         = '0;
        ms_gr_we        = 1'b0;
        ms_excp         = 1'b0;
        ms_excp_num     = '0;
        ms_ertn         = 1'b0;
        ms_csr_we       = 1'b0;
        ms_csr_idx      = '0;
        ms_csr_wdata    = '0;
        ms_ll           = 1'b0;
        ms_sc           = 1'b0;
        ms_error_va     = '0;
        ms_br_inst      = 1'b0;
        ms_br_pre_error = 1'b0;
        ms_mem_inst     = 1'b0;
        break_point     = 1'b0;
        rf_raddr        = '0;
        csr_raddr       = '0;
        n_checks        = 0;
        n_errors        = 0;
        n_timeouts      = 0;
        for (int i = 0; i < 32; i++) model_rf[i] = '0;
        for (int i = 0; i < 128; i++) model_csr[i] = '0;
        for (int i = 0; i < 4; i++) model_cnt[i] = '0;

        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        check_counters();
        check_csr(csr_estat, '0);
        check_csr(csr_llbctl, '0);
        test_reg_writes();
        test_exceptions();
        test_csr_write();
        test_ll_sc();
        test_back_pressure();
        test_counter_mix();

        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d, timeouts: %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          ms_valid,
    input  logic [wb_pkg::xlen-1:0]       ms_pc,
    input  logic [wb_pkg::xlen-1:0]       ms_result,
    input  logic [wb_pkg::reg_addr_w-1:0] ms_dest,
    input  logic                          ms_gr_we,
    input  logic                          ms_excp,
    input  logic [wb_pkg::excp_num_w-1:0] ms_excp_num,
    input  logic                          ms_ertn,
    input  logic                          ms_csr_we,
    input  logic [wb_pkg::csr_addr_w-1:0] ms_csr_idx,
    input  logic [wb_pkg::xlen-1:0]       ms_csr_wdata,
    input  logic                          ms_ll,
    input  logic                          ms_sc,
    input  logic [wb_pkg::xlen-1:0]       ms_error_va,
    input  logic                          ms_br_inst,
    input  logic                          ms_br_pre_error,
    input  logic                          ms_mem_inst,
    input  logic                          break_point,
    input  logic [wb_pkg::reg_addr_w-1:0] rf_raddr,
    input  logic [wb_pkg::csr_addr_w-1:0] csr_raddr,
    output logic                          allowin,
    output logic                          excp_flush,
    output logic                          ertn_flush,
    output logic                          refetch_flush,
    output logic [wb_pkg::xlen-1:0]       rf_rdata,
    output logic [wb_pkg::xlen-1:0]       csr_rdata,
    output logic [wb_pkg::xlen-1:0]       cnt_retired,
    output logic [wb_pkg::xlen-1:0]       cnt_branch,
    output logic [wb_pkg::xlen-1:0]       cnt_mispredict,
    output logic [wb_pkg::xlen-1:0]       cnt_mem
);
    import wb_pkg::*;

    logic                  rf_we;
    logic [reg_addr_w-1:0] rf_waddr;
    logic [xlen-1:0]       rf_wdata;
    logic                  csr_we;
    logic [csr_addr_w-1:0] csr_waddr;
    logic [xlen-1:0]       csr_wdata;
    logic                  excp_commit;
    logic [excp_num_w-1:0] excp_num;
    logic [xlen-1:0]       ws_pc;
    logic [xlen-1:0]       ws_error_va;
    logic                  llbit_set;
    logic                  llbit_val;
    logic                  ev_retired;
    logic                  ev_branch;
    logic                  ev_mispredict;
    logic                  ev_mem;
    logic [ecode_w-1:0]    ecode;
    logic [esubcode_w-1:0] esubcode;
    logic                  va_error;
    logic [xlen-1:0]       bad_va;

    wb_stage u_stage (
        .clk, .arst_n, .ms_valid, .ms_pc, .ms_result, .ms_dest, .ms_gr_we,
        .ms_excp, .ms_excp_num, .ms_ertn, .ms_csr_we, .ms_csr_idx, .ms_csr_wdata,
        .ms_ll, .ms_sc, .ms_error_va, .ms_br_inst, .ms_br_pre_error, .ms_mem_inst,
        .break_point, .allowin, .rf_we, .rf_waddr, .rf_wdata,
        .csr_we_out (csr_we),
        .csr_waddr, .csr_wdata, .excp_commit, .excp_num, .ws_pc, .ws_error_va,
        .llbit_set, .llbit_val, .excp_flush, .ertn_flush, .refetch_flush,
        .ev_retired, .ev_branch, .ev_mispredict, .ev_mem
    );

    excp_encoder u_encoder (
        .excp_num, .pc (ws_pc), .error_va (ws_error_va),
        .ecode, .esubcode, .va_error, .bad_va, .vppn ()
    );

    regfile u_regfile (
        .clk, .arst_n, .we (rf_we), .waddr (rf_waddr), .wdata (rf_wdata),
        .raddr (rf_raddr), .rdata (rf_rdata)
    );

    csr_commit u_csr (
        .clk, .arst_n, .we (csr_we), .waddr (csr_waddr), .wdata (csr_wdata),
        .excp_commit, .ecode, .esubcode, .va_error, .bad_va, .pc (ws_pc),
        .llbit_set, .llbit_val, .raddr (csr_raddr), .rdata (csr_rdata)
    );

    perf_counter u_perf (
        .clk, .arst_n, .ev_retired, .ev_branch, .ev_mispredict, .ev_mem,
        .cnt_retired, .cnt_branch, .cnt_mispredict, .cnt_mem
    );

    // a committed exception must name a cause for the encoder
    a_excp_has_cause: assert property (
        @(posedge clk) disable iff (!arst_n) excp_commit |-> (excp_num != '0)
    );

endmodule

`default_nettype wire

// File: logic/wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           ms_valid,
    input  logic [wb_pkg::xlen-1:0]        ms_pc,
    input  logic [wb_pkg::xlen-1:0]        ms_result,
    input  logic [wb_pkg::reg_addr_w-1:0]  ms_dest,
    input  logic                           ms_gr_we,
    input  logic                           ms_excp,
    input  logic [wb_pkg::excp_num_w-1:0]  ms_excp_num,
    input  logic                           ms_ertn,
    input  logic                           ms_csr_we,
    input  logic [wb_pkg::csr_addr_w-1:0]  ms_csr_idx,
    input  logic [wb_pkg::xlen-1:0]        ms_csr_wdata,
    input  logic                           ms_ll,
    input  logic                           ms_sc,
    input  logic [wb_pkg::xlen-1:0]        ms_error_va,
    input  logic                           ms_br_inst,
    input  logic                           ms_br_pre_error,
    input  logic                           ms_mem_inst,
    input  logic                           break_point,
    output logic                           allowin,
    output logic                           rf_we,
    output logic [wb_pkg::reg_addr_w-1:0]  rf_waddr,
    output logic [wb_pkg::xlen-1:0]        rf_wdata,
    output logic                           csr_we_out,
    output logic [wb_pkg::csr_addr_w-1:0]  csr_waddr,
    output logic [wb_pkg::xlen-1:0]        csr_wdata,
    output logic                           excp_commit,
    output logic [wb_pkg::excp_num_w-1:0]  excp_num,
    output logic [wb_pkg::xlen-1:0]        ws_pc,
    output logic [wb_pkg::xlen-1:0]        ws_error_va,
    output logic                           llbit_set,
    output logic                           llbit_val,
    output logic                           excp_flush,
    output logic                           ertn_flush,
    output logic                           refetch_flush,
    output logic                           ev_retired,
    output logic                           ev_branch,
    output logic                           ev_mispredict,
    output logic                           ev_mem
);
    import wb_pkg::*;

    logic                  ws_valid;
    logic                  ws_go;      // valid and not held by break point
    logic                  real_valid; // committing without exception
    logic                  flush;

    logic [xlen-1:0]       ws_result;
    logic [reg_addr_w-1:0] ws_dest;
    logic                  ws_gr_we;
    logic                  ws_excp;
    logic                  ws_ertn;
    logic                  ws_csr_we;
    logic [csr_addr_w-1:0] ws_csr_idx;
    logic [xlen-1:0]       ws_csr_wdata;
    logic                  ws_ll;
    logic                  ws_sc;
    logic                  ws_br_inst;
    logic                  ws_br_pre_error;
    logic                  ws_mem_inst;

    assign allowin    = !ws_valid || !break_point;
    assign ws_go      = ws_valid && !break_point;
    assign real_valid = ws_go && !ws_excp;
    assign flush      = excp_flush || ertn_flush || refetch_flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ws_valid <= 1'b0;
        end else if (flush) begin
            ws_valid <= 1'b0; // drop whatever arrives behind a flush
        end else if (allowin) begin
            ws_valid <= ms_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ms_valid && allowin) begin
            ws_pc           <= ms_pc;
            ws_result       <= ms_result;
            ws_dest         <= ms_dest;
            ws_gr_we        <= ms_gr_we;
            ws_excp         <= ms_excp;
            excp_num        <= ms_excp_num;
            ws_ertn         <= ms_ertn;
            ws_csr_we       <= ms_csr_we;
            ws_csr_idx      <= ms_csr_idx;
            ws_csr_wdata    <= ms_csr_wdata;
            ws_ll           <= ms_ll;
            ws_sc           <= ms_sc;
            ws_error_va     <= ms_error_va;
            ws_br_inst      <= ms_br_inst;
            ws_br_pre_error <= ms_br_pre_error;
            ws_mem_inst     <= ms_mem_inst;
        end
    end

    assign rf_we    = ws_gr_we && real_valid;
    assign rf_waddr = ws_dest;
    assign rf_wdata = ws_result;

    assign csr_we_out = ws_csr_we && real_valid;
    assign csr_waddr  = ws_csr_idx;
    assign csr_wdata  = ws_csr_wdata;

    assign excp_commit = ws_excp && ws_go;
    assign llbit_set   = (ws_ll || ws_sc) && real_valid;
    assign llbit_val   = ws_ll; // sc clears

    assign excp_flush    = ws_excp && ws_go;
    assign ertn_flush    = ws_ertn && ws_go;
    assign refetch_flush = (ws_csr_we || ((ws_ll || ws_sc) && !ws_excp)) && ws_go;

    // retire events for the counters
    assign ev_retired    = real_valid;
    assign ev_branch     = ws_br_inst && real_valid;
    assign ev_mispredict = ws_br_pre_error && real_valid;
    assign ev_mem        = ws_mem_inst && real_valid;

    // held instruction stays in place while break point is up
    a_hold_under_bp: assert property (
        @(posedge clk) disable iff (!arst_n)
        (ws_valid && break_point) |=> (ws_valid && $stable(ws_pc))
    );

endmodule

`default_nettype wire

// File: logic/perf_counter.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counter (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    ev_retired,
    input  logic                    ev_branch,
    input  logic                    ev_mispredict,
    input  logic                    ev_mem,
    output logic [wb_pkg::xlen-1:0] cnt_retired,
    output logic [wb_pkg::xlen-1:0] cnt_branch,
    output logic [wb_pkg::xlen-1:0] cnt_mispredict,
    output logic [wb_pkg::xlen-1:0] cnt_mem
);
    import wb_pkg::*;

    localparam int n_cnt = 4;

    logic [n_cnt-1:0] ev;
    logic [xlen-1:0]  cnt [n_cnt];

    assign ev = {ev_mem, ev_mispredict, ev_branch, ev_retired};

    for (genvar i = 0; i < n_cnt; i++) begin : g_cnt
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                cnt[i] <= '0;
            end else if (ev[i]) begin
                cnt[i] <= cnt[i] + 1'b1; // wraps
            end
        end
    end

    assign cnt_retired    = cnt[0];
    assign cnt_branch     = cnt[1];
    assign cnt_mispredict = cnt[2];
    assign cnt_mem        = cnt[3];

endmodule

`default_nettype wire

// File: logic/csr_commit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_commit (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          we,
    input  logic [wb_pkg::csr_addr_w-1:0] waddr,
    input  logic [wb_pkg::xlen-1:0]       wdata,
    input  logic                          excp_commit,
    input  logic [wb_pkg::ecode_w-1:0]    ecode,
    input  logic [wb_pkg::esubcode_w-1:0] esubcode,
    input  logic                          va_error,
    input  logic [wb_pkg::xlen-1:0]       bad_va,
    input  logic [wb_pkg::xlen-1:0]       pc,
    input  logic                          llbit_set,
    input  logic                          llbit_val,
    input  logic [wb_pkg::csr_addr_w-1:0] raddr,
    output logic [wb_pkg::xlen-1:0]       rdata
);
    import wb_pkg::*;

    logic [xlen-1:0] era;
    logic [xlen-1:0] estat;
    logic [xlen-1:0] badv;
    logic [xlen-1:0] save0;
    logic [xlen-1:1] llbctl_hi; // software bits of llbctl
    logic            llbit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            era       <= '0;
            estat     <= '0;
            badv      <= '0;
            save0     <= '0;
            llbctl_hi <= '0;
        end else if (excp_commit) begin
            era          <= pc;
            estat[21:16] <= ecode;
            estat[30:22] <= esubcode;
            if (va_error) begin
                badv <= bad_va;
            end
        end else if (we) begin
            case (waddr)
                csr_era:    era       <= wdata;
                csr_estat:  estat     <= wdata;
                csr_badv:   badv      <= wdata;
                csr_save0:  save0     <= wdata;
                csr_llbctl: llbctl_hi <= wdata[xlen-1:1];
                default:    ;
            endcase
        end
    end

    // ll sets, sc clears
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            llbit <= 1'b0;
        end else if (llbit_set) begin
            llbit <= llbit_val;
        end
    end

    always_comb begin
        case (raddr)
            csr_era:    rdata = era;
            csr_estat:  rdata = estat;
            csr_badv:   rdata = badv;
            csr_save0:  rdata = save0;
            csr_llbctl: rdata = {llbctl_hi, llbit};
            default:    rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/excp_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module excp_encoder (
    input  logic [wb_pkg::excp_num_w-1:0] excp_num,
    input  logic [wb_pkg::xlen-1:0]       pc,
    input  logic [wb_pkg::xlen-1:0]       error_va,
    output logic [wb_pkg::ecode_w-1:0]    ecode,
    output logic [wb_pkg::esubcode_w-1:0] esubcode,
    output logic                          va_error,
    output logic [wb_pkg::xlen-1:0]       bad_va,
    output logic [wb_pkg::vppn_w-1:0]     vppn
);
    import wb_pkg::*;

    int sel;   // lowest set cause bit, -1 when none

    always_comb begin
        sel = -1;
        for (int i = excp_num_w - 1; i >= 0; i--) begin
            if (excp_num[i]) begin
                sel = i;
            end
        end
    end

    always_comb begin
        ecode    = ecode_int;
        esubcode = '0;
        va_error = 1'b0;
        bad_va   = '0;
        case (sel)
            excp_bit_int:    ecode = ecode_int;
            excp_bit_adef: begin
                ecode    = ecode_adef;
                esubcode = esubcode_adef;
            end
            excp_bit_tlbr_i: ecode = ecode_tlbr;
            excp_bit_pif:    ecode = ecode_pif;
            excp_bit_ppi_i:  ecode = ecode_ppi;
            excp_bit_sys:    ecode = ecode_sys;
            excp_bit_brk:    ecode = ecode_brk;
            excp_bit_ine:    ecode = ecode_ine;
            excp_bit_ipe:    ecode = ecode_ipe;
            excp_bit_ale:    ecode = ecode_ale;
            excp_bit_tlbr_d: ecode = ecode_tlbr;
            excp_bit_pme:    ecode = ecode_pme;
            excp_bit_ppi_d:  ecode = ecode_ppi;
            excp_bit_pis:    ecode = ecode_pis;
            excp_bit_pil:    ecode = ecode_pil;
            default:         ecode = ecode_int;
        endcase
        // fetch side causes report the pc
        if (sel >= excp_bit_adef && sel <= excp_bit_ppi_i) begin
            va_error = 1'b1;
            bad_va   = pc;
        end
        if (sel == excp_bit_ale || sel >= excp_bit_tlbr_d) begin
            va_error = 1'b1;
            bad_va   = error_va; // data side
        end
    end

    assign vppn = bad_va[xlen-1 -: vppn_w];

endmodule

`default_nettype wire

// File: logic/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          we,
    input  logic [wb_pkg::reg_addr_w-1:0] waddr,
    input  logic [wb_pkg::xlen-1:0]       wdata,
    input  logic [wb_pkg::reg_addr_w-1:0] raddr,
    output logic [wb_pkg::xlen-1:0]       rdata
);
    import wb_pkg::*;

    localparam int depth = 1 << reg_addr_w;

    logic [xlen-1:0] rf [depth];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < depth; i++) begin
                rf[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            rf[waddr] <= wdata; // r0 writes dropped
        end
    end

    assign rdata = (raddr == '0) ? '0 : rf[raddr];

    // a write always names a defined register
    a_waddr_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        we |-> !$isunknown(waddr)
    );

endmodule

`default_nettype wire

// File: logic/wb_pkg.sv
`default_nettype none

package wb_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int csr_addr_w = 14;
    localparam int excp_num_w = 16;
    localparam int ecode_w    = 6;
    localparam int esubcode_w = 9;
    localparam int vppn_w     = 19;

    // csr indices
    localparam logic [csr_addr_w-1:0] csr_estat  = 14'd5;
    localparam logic [csr_addr_w-1:0] csr_era    = 14'd6;
    localparam logic [csr_addr_w-1:0] csr_badv   = 14'd7;
    localparam logic [csr_addr_w-1:0] csr_save0  = 14'd48;
    localparam logic [csr_addr_w-1:0] csr_llbctl = 14'd96;

    // architectural exception codes
    localparam logic [ecode_w-1:0] ecode_int  = 6'h00;
    localparam logic [ecode_w-1:0] ecode_pil  = 6'h01;
    localparam logic [ecode_w-1:0] ecode_pis  = 6'h02;
    localparam logic [ecode_w-1:0] ecode_pif  = 6'h03;
    localparam logic [ecode_w-1:0] ecode_pme  = 6'h04;
    localparam logic [ecode_w-1:0] ecode_ppi  = 6'h07;
    localparam logic [ecode_w-1:0] ecode_adef = 6'h08;
    localparam logic [ecode_w-1:0] ecode_ale  = 6'h09;
    localparam logic [ecode_w-1:0] ecode_sys  = 6'h0b;
    localparam logic [ecode_w-1:0] ecode_brk  = 6'h0c;
    localparam logic [ecode_w-1:0] ecode_ine  = 6'h0d;
    localparam logic [ecode_w-1:0] ecode_ipe  = 6'h0e;
    localparam logic [ecode_w-1:0] ecode_tlbr = 6'h3f;

    localparam logic [esubcode_w-1:0] esubcode_adef = 9'd0;

    // cause bit positions, lower index wins
    localparam int excp_bit_int    = 0;
    localparam int excp_bit_adef   = 1;
    localparam int excp_bit_tlbr_i = 2;  // fetch side tlb causes 2..4
    localparam int excp_bit_pif    = 3;
    localparam int excp_bit_ppi_i  = 4;
    localparam int excp_bit_sys    = 5;
    localparam int excp_bit_brk    = 6;
    localparam int excp_bit_ine    = 7;
    localparam int excp_bit_ipe    = 8;
    localparam int excp_bit_ale    = 9;
    localparam int excp_bit_tlbr_d = 11; // bit 10 unused
    localparam int excp_bit_pme    = 12;
    localparam int excp_bit_ppi_d  = 13;
    localparam int excp_bit_pis    = 14;
    localparam int excp_bit_pil    = 15;

endpackage

`default_nettype wire
